//--- src/video_pkg.sv
package video_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // coordinate widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // sized for the largest timing the top level may be given
    localparam int X_BITS = 12;
    localparam int Y_BITS = 11;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // video types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // rgb565 camera pixel
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pixel_t;

    // all active high
    typedef struct packed {
        logic vsync;
        logic hsync;
        logic de;
    } video_sync_t;

    // position inside the active area
    typedef struct packed {
        logic [X_BITS-1:0] x;
        logic [Y_BITS-1:0] y;
    } video_pos_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lock controller states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        UNLOCKED   = 2'b00,
        BLANK_WAIT = 2'b01,
        DELAYING   = 2'b10,
        LOCKED     = 2'b11
    } lock_state_t;

endpackage : video_pkg

//--- src/frame_lock.sv
`timescale 1ns/100ps

module frame_lock #(
    parameter int THRESH = 16,
    parameter int DELAY  = 4
) (
    input  logic clk,
    input  logic rstn,
    input  logic cam_href,
    output logic timing_rstn,
    output logic locked
);
    import video_pkg::*;

    // one counter serves both the blank threshold and the delay
    localparam int CNT_MAX = (THRESH > DELAY) ? THRESH : DELAY;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    localparam logic [CNT_W-1:0] THRESH_LAST = CNT_W'(THRESH - 1);
    localparam logic [CNT_W-1:0] DELAY_LAST  = CNT_W'(DELAY - 1);

    lock_state_t      state;
    logic             href_d;
    logic [CNT_W-1:0] cnt;
    logic             release_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lock fsm
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= UNLOCKED;
            href_d    <= 1'b0;
            cnt       <= '0;
            release_q <= 1'b0;
        end else begin
            href_d <= cam_href;
            case (state)
                UNLOCKED: begin
                    // falling edge of href may start the vertical blank
                    if (!cam_href && href_d) begin
                        state <= BLANK_WAIT;
                        cnt   <= '0;
                    end
                end
                BLANK_WAIT: begin
                    if (cam_href) begin
                        // only a line gap
                        state <= UNLOCKED;
                    end else if (cnt == THRESH_LAST) begin
                        cnt   <= '0;
                        state <= DELAYING;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                DELAYING: begin
                    if (cnt == DELAY_LAST) begin
                        state     <= LOCKED;
                        release_q <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                LOCKED: begin
                    // stays here until the external reset
                    release_q <= 1'b1;
                end
                default: begin
                    state <= UNLOCKED;
                end
            endcase
        end
    end

    assign timing_rstn = release_q;
    assign locked      = (state == LOCKED);

    // lock is one-way until the next external reset
    a_lock_held: assert property (@(posedge clk) disable iff (!rstn)
        locked |=> locked);

    // the timing release follows the state register exactly
    a_release_matches_lock: assert property (@(posedge clk) disable iff (!rstn)
        timing_rstn == locked);

endmodule : frame_lock

//--- src/video_timing.sv
`timescale 1ns/100ps

module video_timing #(
    parameter int H_ACT  = 8,
    parameter int H_FP   = 2,
    parameter int H_SYNC = 2,
    parameter int H_BP   = 2,
    parameter int V_ACT  = 4,
    parameter int V_FP   = 1,
    parameter int V_SYNC = 1,
    parameter int V_BP   = 1
) (
    input  logic                   clk,
    input  logic                   rstn,
    output logic                   read_en,
    output video_pkg::video_sync_t sync,
    output video_pkg::video_pos_t  pos
);
    import video_pkg::*;

    localparam int H_TOTAL = H_ACT + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACT + V_FP + V_SYNC + V_BP;

    // one spare count so the region ends always fit
    localparam int HC_W = $clog2(H_TOTAL + 1);
    localparam int VC_W = $clog2(V_TOTAL + 1);

    localparam logic [HC_W-1:0] H_LAST   = HC_W'(H_TOTAL - 1);
    localparam logic [HC_W-1:0] H_ACT_E  = HC_W'(H_ACT);
    localparam logic [HC_W-1:0] HS_START = HC_W'(H_ACT + H_FP);
    localparam logic [HC_W-1:0] HS_END   = HC_W'(H_ACT + H_FP + H_SYNC);

    localparam logic [VC_W-1:0] V_LAST   = VC_W'(V_TOTAL - 1);
    localparam logic [VC_W-1:0] V_ACT_E  = VC_W'(V_ACT);
    localparam logic [VC_W-1:0] VS_START = VC_W'(V_ACT + V_FP);
    localparam logic [VC_W-1:0] VS_END   = VC_W'(V_ACT + V_FP + V_SYNC);

    if (H_TOTAL > (1 << X_BITS) || V_TOTAL > (1 << Y_BITS)) begin : g_size_check
        $error("video_timing: totals do not fit the position fields");
    end

    logic [HC_W-1:0] h_cnt;
    logic [VC_W-1:0] v_cnt;
    logic            h_active;
    logic            v_active;
    logic            h_sync_zone;
    logic            v_sync_zone;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raster counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // line: active, front porch, sync, back porch
    assign h_active    = (h_cnt < H_ACT_E);
    assign h_sync_zone = (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign v_active    = (v_cnt < V_ACT_E);
    assign v_sync_zone = (v_cnt >= VS_START) && (v_cnt < VS_END);

    // held off until the lock releases the generator
    assign read_en = rstn && h_active && v_active;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output stage, one behind read_en
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync <= '0;
            pos  <= '0;
        end else begin
            sync.de    <= read_en;
            sync.hsync <= h_sync_zone;
            sync.vsync <= v_sync_zone;
            if (read_en) begin
                pos.x <= X_BITS'(h_cnt);
                pos.y <= Y_BITS'(v_cnt);
            end
        end
    end

    a_de_in_active: assert property (@(posedge clk) disable iff (!rstn)
        sync.de |-> (pos.x < X_BITS'(H_ACT)) && (pos.y < Y_BITS'(V_ACT)));

    // the buffer's registered read depends on this one-cycle lead
    a_de_follows_read: assert property (@(posedge clk) disable iff (!rstn)
        sync.de == $past(read_en));

endmodule : video_timing

//--- src/pixel_fifo.sv
`timescale 1ns/100ps

module pixel_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 16
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     overflow,
    output logic     underflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == CNT_FULL);
    assign empty = (count == '0);
    // no back-pressure, lost accesses only show up in the flags
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // storage and read register
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset
            if (wr_en && full) begin
                overflow <= 1'b1;
            end
            if (rd_en && empty) begin
                underflow <= 1'b1;
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= CNT_FULL);

endmodule : pixel_fifo

//--- src/cam_display_top.sv
`timescale 1ns/100ps

module cam_display_top #(
    parameter int H_ACT  = 8,
    parameter int H_FP   = 2,
    parameter int H_SYNC = 2,
    parameter int H_BP   = 2,
    parameter int V_ACT  = 4,
    parameter int V_FP   = 1,
    parameter int V_SYNC = 1,
    parameter int V_BP   = 1,
    parameter int THRESH = 16,
    parameter int DELAY  = 4,
    parameter int DEPTH  = 16
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   cam_href,
    input  video_pkg::pixel_t      cam_pixel,
    output video_pkg::video_sync_t sync,
    output video_pkg::video_pos_t  pos,
    output video_pkg::pixel_t      pixel_out,
    output logic                   locked,
    output logic                   overflow,
    output logic                   underflow
);
    import video_pkg::*;

    logic timing_rstn;
    logic vt_rstn;
    logic read_en;

    // generator runs only once the camera blank has been found
    assign vt_rstn = rstn & timing_rstn;

    frame_lock #(
        .THRESH(THRESH),
        .DELAY (DELAY )
    ) i_frame_lock (
        .clk        (clk        ),
        .rstn       (rstn       ),
        .cam_href   (cam_href   ),
        .timing_rstn(timing_rstn),
        .locked     (locked     )
    );

    video_timing #(
        .H_ACT (H_ACT ),
        .H_FP  (H_FP  ),
        .H_SYNC(H_SYNC),
        .H_BP  (H_BP  ),
        .V_ACT (V_ACT ),
        .V_FP  (V_FP  ),
        .V_SYNC(V_SYNC),
        .V_BP  (V_BP  )
    ) i_video_timing (
        .clk    (clk    ),
        .rstn   (vt_rstn),
        .read_en(read_en),
        .sync   (sync   ),
        .pos    (pos    )
    );

    pixel_fifo #(
        .payload_t(pixel_t),
        .DEPTH    (DEPTH  )
    ) i_pixel_fifo (
        .clk      (clk      ),
        .rstn     (rstn     ),
        .wr_en    (cam_href ),
        .wr_data  (cam_pixel),
        .rd_en    (read_en  ),
        .rd_data  (pixel_out),
        .overflow (overflow ),
        .underflow(underflow)
    );

endmodule : cam_display_top

//--- testbench/tb_cam_display.sv
`timescale 1ns/100ps

module tb_cam_display;
    import video_pkg::*;

    localparam int H_ACT    = 8;
    localparam int H_FP     = 2;
    localparam int H_SYNC   = 2;
    localparam int H_BP     = 2;
    localparam int V_ACT    = 4;
    localparam int V_FP     = 1;
    localparam int V_SYNC   = 1;
    localparam int V_BP     = 1;
    localparam int THRESH   = 16;
    localparam int DELAY    = 4;
    localparam int DEPTH    = 16;
    localparam int H_TOTAL  = H_ACT + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL  = V_ACT + V_FP + V_SYNC + V_BP;
    // edge detect, threshold count, then the delay
    localparam int LOCK_LAT = THRESH + DELAY + 1;
    localparam int N_ROWS   = 4;
    localparam int N_FRAMES = 3;
    localparam int WATCHDOG = (N_ROWS + N_FRAMES) * V_TOTAL * H_TOTAL * 2;

    typedef struct packed {
        int   gap;
        int   pulse_at;
        int   frames;
        logic expect_lock;
    } row_t;

    logic        clk;
    logic        rstn;
    logic        cam_href;
    pixel_t      cam_pixel;
    video_sync_t sync;
    video_pos_t  pos;
    pixel_t      pixel_out;
    logic        locked;
    logic        overflow;
    logic        underflow;

    row_t        rows [N_ROWS];
    pixel_t      model_q [$];
    logic [31:0] rng;
    int          cyc;
    int          lock_fall;
    logic        lock_wanted;
    logic        frame_row;

    // display side monitor state
    video_sync_t sync_d         = '0;
    pixel_t      exp_px;
    int          exp_x          = 0;
    int          exp_y          = 0;
    int          de_run         = 0;
    int          vs_run         = 0;
    int          lines_in_frame = 0;
    int          frames_seen    = 0;
    int          vsync_frames   = 0;
    int          h_phase        = -1;

    cam_display_top #(
        .H_ACT (H_ACT ), .H_FP  (H_FP  ), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACT (V_ACT ), .V_FP  (V_FP  ), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .THRESH(THRESH), .DELAY (DELAY ), .DEPTH (DEPTH )
    ) i_cam_display_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: the run did not end within %0d cycles", WATCHDOG);
        $display("Test failed");
        $fatal(1);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic apply_reset(input logic watch_flags);
        @(posedge clk);
        rstn      <= 1'b0;
        cam_href  <= 1'b0;
        frame_row = watch_flags;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        model_q.delete();
        lock_fall = -1;
        @(negedge clk);
        check_value(32'(locked), 32'd0, "locked after reset");
        check_value(32'(overflow), 32'd0, "overflow after reset");
        check_value(32'(underflow), 32'd0, "underflow after reset");
    endtask

    // one camera cycle with the lock checked mid-cycle
    task automatic drive_cycle(input logic href);
        logic exp_lock;
        cyc = cyc + 1;
        @(posedge clk);
        cam_href <= href;
        if (href) begin
            rng = lcg_next(rng);
            cam_pixel <= pixel_t'(rng[31:16]);
            model_q.push_back(pixel_t'(rng[31:16]));
        end
        @(negedge clk);
        exp_lock = lock_wanted && (lock_fall >= 0) && (cyc - lock_fall >= LOCK_LAT);
        check_value(32'(locked), 32'(exp_lock), "locked");
    endtask

    task automatic send_line();
        repeat (H_ACT) drive_cycle(1'b1);
    endtask

    task automatic send_low(input int n);
        repeat (n) drive_cycle(1'b0);
    endtask

    task automatic send_frame();
        repeat (V_ACT) begin
            send_line();
            send_low(H_TOTAL - H_ACT);
        end
        send_low((V_TOTAL - V_ACT) * H_TOTAL);
    endtask

    task automatic run_row(input row_t r);
        lock_wanted = r.expect_lock;
        send_line();
        lock_fall = cyc + 1;
        if (r.pulse_at > 0) begin
            send_low(r.pulse_at);
            drive_cycle(1'b1);
            send_low(r.gap - r.pulse_at - 1);
        end else begin
            send_low(r.gap);
        end
        if (r.frames == 0) begin
            // a closing line ends the gap
            send_line();
        end else begin
            repeat (r.frames) send_frame();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rstn        <= 1'b0;
        cam_href    <= 1'b0;
        cam_pixel   <= '0;
        rng         = 32'd47;
        cyc         = 0;
        lock_fall   = -1;
        lock_wanted = 1'b0;
        frame_row   = 1'b0;
        rows[0] = '{gap: H_TOTAL - H_ACT, pulse_at: 0, frames: 0, expect_lock: 1'b0};
        rows[1] = '{gap: 12, pulse_at: 0, frames: 0, expect_lock: 1'b0};
        rows[2] = '{gap: 24, pulse_at: 10, frames: 0, expect_lock: 1'b0};
        // camera leads the display by one line from here on
        rows[3] = '{gap: THRESH + 1, pulse_at: 0, frames: N_FRAMES, expect_lock: 1'b1};
        for (int i = 0; i < N_ROWS; i++) begin
            apply_reset(rows[i].frames > 0);
            run_row(rows[i]);
        end
        check_value(32'(frames_seen), N_FRAMES, "frames displayed");
        check_value(32'(vsync_frames), N_FRAMES, "vsync pulses");
        // the last camera line waits for the next display frame
        check_value(32'(model_q.size()), H_ACT, "pixels left in buffer");
        $display("Test completed successfully");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // display monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        forever begin
            @(negedge clk);
            if (!locked) begin
                check_value(32'(sync), 32'd0, "sync before lock");
                check_value(32'(pos), 32'd0, "pos before lock");
                h_phase = -1;
            end else if (h_phase < 0 && sync.de) begin
                // line phase starts with the first de after lock
                h_phase = 0;
            end
            if (h_phase >= 0) begin
                check_value(32'(sync.hsync),
                            32'(h_phase >= H_ACT + H_FP && h_phase < H_ACT + H_FP + H_SYNC),
                            "hsync");
                h_phase = (h_phase + 1) % H_TOTAL;
            end
            if (frame_row) begin
                check_value(32'(overflow), 32'd0, "overflow");
                check_value(32'(underflow), 32'd0, "underflow");
            end
            if (sync.de) begin
                check_value(32'(model_q.size() > 0), 32'd1, "pixel pending at de");
                exp_px = model_q.pop_front();
                check_value(32'(pixel_out), 32'(exp_px), "pixel_out");
                check_value(32'(pos.x), 32'(exp_x), "pos.x");
                check_value(32'(pos.y), 32'(exp_y), "pos.y");
                de_run++;
                exp_x++;
                if (exp_x == H_ACT) begin
                    exp_x = 0;
                    exp_y++;
                end
                if (exp_y == V_ACT) begin
                    exp_y = 0;
                    frames_seen++;
                end
            end else if (sync_d.de) begin
                check_value(32'(de_run), H_ACT, "de cycles in line");
                de_run = 0;
                lines_in_frame++;
            end
            if (sync.vsync && !sync_d.vsync) begin
                check_value(32'(lines_in_frame), V_ACT, "de lines in frame");
                lines_in_frame = 0;
            end
            if (sync.vsync) begin
                vs_run++;
            end else if (sync_d.vsync) begin
                check_value(32'(vs_run), V_SYNC * H_TOTAL, "vsync cycles");
                vs_run = 0;
                vsync_frames++;
            end
            sync_d = sync;
        end
    end

endmodule : tb_cam_display

//--- files.f
src/video_pkg.sv
src/frame_lock.sv
src/video_timing.sv
src/pixel_fifo.sv
src/cam_display_top.sv
testbench/tb_cam_display.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line
verilator --binary --timing --assert -f files.f --top-module tb_cam_display \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_cam_display)
echo "$out"
echo "$out" | grep -qx "Test completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
